// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module invadersTb -Mdir build -o invadersSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build/invadersSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1

// File: src/alienRow.sv
`timescale 1ns/1ps

module alienRow
    import invadersPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  rocket_t               rocket,
    output logic                  hit,
    output alienMask_t            alive,
    output logic [ScoreWidth-1:0] score,
    output logic                  win
);

    alienMask_t hitVec;

    // Compare the rocket against every live alien.
    always_comb
    begin
        xCoord_t alienX;
        hitVec = '0;
        for (int i = 0; i < AlienCount; i++)
        begin
            alienX = AlienX0 + xCoord_t'(i) * AlienPitch;
            hitVec[i] = rocket.flying && alive[i]
                && (rocket.y == AlienRowY)
                && (rocket.x >= alienX - HitMargin)
                && (rocket.x <= alienX + AlienWidth + HitMargin);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hit <= 1'b0;
            alive <= '1;
            score <= '0;
            win <= 1'b0;
        end
        else
        begin
            hit <= |hitVec;
            alive <= alive & ~hitVec;
            if (|hitVec)
            begin
                score <= score + ScorePerAlien;
            end
            // Follows the alive register by one cycle.
            win <= (alive == '0);
        end
    end

endmodule

// File: src/buttonConditioner.sv
`timescale 1ns/1ps

module buttonConditioner
    import invadersPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic raw,
    output logic pulse
);

    typedef logic [$clog2(DebounceCycles)-1:0] debounce_t;
    typedef logic [$clog2(RepeatCycles)-1:0] repeat_t;

    debounce_t stableCount;
    repeat_t   repeatCount;
    logic      clean;

    // Clean level rises after DebounceCycles high samples in a row.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            stableCount <= '0;
            clean <= 1'b0;
        end
        else if (!raw)
        begin
            stableCount <= '0;
            clean <= 1'b0;
        end
        else if (stableCount == debounce_t'(DebounceCycles - 1))
        begin
            clean <= 1'b1;
        end
        else
        begin
            stableCount <= stableCount + 1'b1;
        end
    end

    // Auto-repeat while held; drops at once on release.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            repeatCount <= '0;
            pulse <= 1'b0;
        end
        else if (!clean || !raw)
        begin
            repeatCount <= '0;
            pulse <= 1'b0;
        end
        else if (repeatCount == repeat_t'(RepeatCycles - 1))
        begin
            repeatCount <= '0;
            pulse <= 1'b1;
        end
        else
        begin
            repeatCount <= repeatCount + 1'b1;
            pulse <= 1'b0;
        end
    end

endmodule

// File: src/invadersPkg.sv
package invadersPkg;

    // Screen coordinates.
    localparam int XWidth = 10;
    localparam int YWidth = 9;

    typedef logic [XWidth-1:0] xCoord_t;
    typedef logic [YWidth-1:0] yCoord_t;

    // Ship.
    localparam xCoord_t ShipStartX = 10'd310;
    localparam yCoord_t ShipY = 9'd400;
    localparam xCoord_t ShipMinX = 10'd11;
    localparam xCoord_t ShipMaxX = 10'd598;

    // Player rocket.
    localparam xCoord_t RocketOffsetX = 10'd13;
    localparam yCoord_t RocketTopY = 9'd10;
    localparam int RocketStepCycles = 4;

    // Alien i sits at AlienX0 + i * AlienPitch.
    localparam int AlienCount = 5;
    localparam xCoord_t AlienWidth = 10'd30;
    localparam yCoord_t AlienRowY = 9'd150;
    localparam xCoord_t AlienX0 = 10'd220;
    localparam xCoord_t AlienPitch = 10'd70;
    localparam xCoord_t HitMargin = 10'd2;

    // Scoring.
    localparam int ScoreWidth = 7;
    localparam logic [ScoreWidth-1:0] ScorePerAlien = 7'd3;

    // Button conditioning and tone timing in clk cycles.
    localparam int DebounceCycles = 16;
    localparam int RepeatCycles = 8;
    localparam int ToneHalfPeriod = 5;
    localparam int TonePlayCycles = 200;

    typedef struct packed {
        logic left;
        logic right;
        logic fire;
    } buttons_t;

    typedef struct packed {
        logic    flying;
        xCoord_t x;
        yCoord_t y;
    } rocket_t;

    // Bit i is alien i.
    typedef logic [AlienCount-1:0] alienMask_t;

endpackage

// File: src/invadersTop.sv
`timescale 1ns/1ps

module invadersTop
    import invadersPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  buttons_t              buttons,
    output xCoord_t               shipX,
    output rocket_t               rocket,
    output alienMask_t            alive,
    output logic [ScoreWidth-1:0] score,
    output logic                  win,
    output logic                  speaker
);

    buttons_t pulses;
    logic     hit;

    buttonConditioner leftCond_i (
        .clk   (clk),
        .rst   (rst),
        .raw   (buttons.left),
        .pulse (pulses.left)
    );

    buttonConditioner rightCond_i (
        .clk   (clk),
        .rst   (rst),
        .raw   (buttons.right),
        .pulse (pulses.right)
    );

    buttonConditioner fireCond_i (
        .clk   (clk),
        .rst   (rst),
        .raw   (buttons.fire),
        .pulse (pulses.fire)
    );

    playerUnit playerUnit_i (
        .clk    (clk),
        .rst    (rst),
        .pulses (pulses),
        .hit    (hit),
        .shipX  (shipX),
        .rocket (rocket)
    );

    alienRow alienRow_i (
        .clk    (clk),
        .rst    (rst),
        .rocket (rocket),
        .hit    (hit),
        .alive  (alive),
        .score  (score),
        .win    (win)
    );

    toneGenerator toneGenerator_i (
        .clk     (clk),
        .rst     (rst),
        .hit     (hit),
        .speaker (speaker)
    );

endmodule

// File: src/playerUnit.sv
`timescale 1ns/1ps

module playerUnit
    import invadersPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  buttons_t pulses,
    input  logic     hit,
    output xCoord_t  shipX,
    output rocket_t  rocket
);

    typedef logic [$clog2(RocketStepCycles)-1:0] step_t;

    step_t stepCount;

    // Left has priority over right.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shipX <= ShipStartX;
        end
        else if (pulses.left)
        begin
            if (shipX > ShipMinX)
            begin
                shipX <= shipX - 1'b1;
            end
        end
        else if (pulses.right)
        begin
            if (shipX < ShipMaxX)
            begin
                shipX <= shipX + 1'b1;
            end
        end
    end

    // One rocket at a time climbs one row per step.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rocket <= '0;
            stepCount <= '0;
        end
        else if (!rocket.flying)
        begin
            if (pulses.fire)
            begin
                rocket.flying <= 1'b1;
                rocket.x <= shipX + RocketOffsetX;
                rocket.y <= ShipY;
                stepCount <= '0;
            end
        end
        else if (hit || rocket.y == RocketTopY)
        begin
            rocket.flying <= 1'b0;
        end
        else if (stepCount == step_t'(RocketStepCycles - 1))
        begin
            stepCount <= '0;
            rocket.y <= rocket.y - 1'b1;
        end
        else
        begin
            stepCount <= stepCount + 1'b1;
        end
    end

endmodule

// File: src/toneGenerator.sv
`timescale 1ns/1ps

module toneGenerator
    import invadersPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic hit,
    output logic speaker
);

    typedef logic [$clog2(TonePlayCycles + 1)-1:0] play_t;
    typedef logic [$clog2(ToneHalfPeriod)-1:0] half_t;

    play_t playCount;
    half_t halfCount;
    logic  toneBit;
    logic  playing;

    assign playing = (playCount != '0);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            playCount <= '0;
            halfCount <= '0;
            toneBit <= 1'b0;
        end
        else
        begin
            // A new hit restarts the window.
            if (hit)
            begin
                playCount <= play_t'(TonePlayCycles);
            end
            else if (playing)
            begin
                playCount <= playCount - 1'b1;
            end

            if (!playing)
            begin
                halfCount <= '0;
                toneBit <= 1'b0;
            end
            else if (halfCount == half_t'(ToneHalfPeriod - 1))
            begin
                halfCount <= '0;
                toneBit <= ~toneBit;
            end
            else
            begin
                halfCount <= halfCount + 1'b1;
            end
        end
    end

    assign speaker = toneBit && playing;

endmodule

// File: tb.f
src/invadersPkg.sv
src/buttonConditioner.sv
src/playerUnit.sv
src/alienRow.sv
src/toneGenerator.sv
src/invadersTop.sv
tb/invadersChecker.sv
tb/invadersTb.sv

// File: tb/invadersChecker.sv
`timescale 1ns/1ps

module invadersChecker
    import invadersPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  xCoord_t               shipX,
    input  rocket_t               rocket,
    input  alienMask_t            alive,
    input  logic [ScoreWidth-1:0] score,
    input  logic                  win,
    input  logic                  speaker,
    input  logic                  rowDone,
    input  xCoord_t               expMinX,
    input  xCoord_t               expMaxX,
    input  alienMask_t            expAlive,
    input  logic [ScoreWidth-1:0] expScore,
    input  logic                  expWin,
    input  logic                  done,
    output int                    errors
);

    int errorCount = 0;
    int rowChecks = 0;
    int sinceHit;
    logic running;
    logic hitSeen;
    logic toggled;
    logic prevSpeaker;
    rocket_t prevRocket;
    xCoord_t prevShipX;
    alienMask_t prevAlive;
    logic [ScoreWidth-1:0] prevScore;

    assign errors = errorCount;

    task automatic report(input string msg);
        errorCount++;
        $display("FAIL at %0t: %s", $time, msg);
    endtask

    // Outputs are read at the rising edge, before this edge's updates land.
    always @(posedge clk)
    begin
        if (rst)
        begin
            running = 1'b0;
            hitSeen = 1'b0;
            toggled = 1'b0;
            sinceHit = TonePlayCycles + 10;
        end
        else
        begin
            if (!running)
            begin
                if (shipX != ShipStartX || rocket.flying || alive != '1 || score != '0
                    || win || speaker)
                begin
                    report("outputs do not hold their reset values");
                end
            end
            else
            begin
                // A score change must be one hit on one live alien.
                if (score != prevScore)
                begin
                    if (score != prevScore + ScorePerAlien)
                    begin
                        report($sformatf("score went from %0d to %0d", prevScore, score));
                    end
                    if ($countones(prevAlive & ~alive) != 1 || (alive & ~prevAlive) != '0)
                    begin
                        report($sformatf("alive went from %b to %b", prevAlive, alive));
                    end
                    hitSeen = 1'b1;
                    toggled = 1'b0;
                    sinceHit = 0;
                end
                else if (alive != prevAlive)
                begin
                    report("alive changed without a score change");
                end
                if (win != (prevAlive == '0))
                begin
                    report($sformatf("win is %b one cycle after alive %b", win, prevAlive));
                end
                if (shipX < ShipMinX || shipX > ShipMaxX)
                begin
                    report($sformatf("shipX %0d is past a limit", shipX));
                end
                if (shipX != prevShipX && shipX != prevShipX + 1'b1 && shipX != prevShipX - 1'b1)
                begin
                    report($sformatf("shipX jumped from %0d to %0d", prevShipX, shipX));
                end
                if (rocket.flying && !prevRocket.flying)
                begin
                    if (rocket.y != ShipY || rocket.x != prevShipX + RocketOffsetX)
                    begin
                        report($sformatf("launch at x %0d y %0d", rocket.x, rocket.y));
                    end
                    hitSeen = 1'b0;
                end
                else if (rocket.flying)
                begin
                    if (rocket.x != prevRocket.x
                        || (rocket.y != prevRocket.y && rocket.y != prevRocket.y - 1'b1))
                    begin
                        report($sformatf("rocket moved from y %0d to y %0d",
                            prevRocket.y, rocket.y));
                    end
                    if (hitSeen && rocket.y < AlienRowY)
                    begin
                        report("rocket still flying below the alien row after a hit");
                    end
                end
                else if (prevRocket.flying && !hitSeen && prevRocket.y != RocketTopY)
                begin
                    report($sformatf("rocket stopped at y %0d without a hit", prevRocket.y));
                end
                // Tone window starts with the hit.
                if (sinceHit <= TonePlayCycles + 3)
                begin
                    if (speaker != prevSpeaker)
                    begin
                        toggled = 1'b1;
                    end
                    if (sinceHit == TonePlayCycles && !toggled)
                    begin
                        report("speaker never toggled after a hit");
                    end
                    sinceHit++;
                end
                else if (speaker)
                begin
                    report("speaker active outside the play window");
                end
            end

            if (rowDone)
            begin
                rowChecks++;
                if (shipX < expMinX || shipX > expMaxX)
                begin
                    report($sformatf("shipX %0d not in %0d..%0d", shipX, expMinX, expMaxX));
                end
                if (alive != expAlive || score != expScore || win != expWin)
                begin
                    report($sformatf("alive %b score %0d win %b, expected %b %0d %b",
                        alive, score, win, expAlive, expScore, expWin));
                end
                if (rocket.flying || speaker)
                begin
                    report("rocket or speaker still active at the end of a row");
                end
            end
            if (done)
            begin
                $display("Checker: %0d row checks, %0d errors", rowChecks, errorCount);
            end

            running = 1'b1;
            prevRocket = rocket;
            prevShipX = shipX;
            prevAlive = alive;
            prevScore = score;
            prevSpeaker = speaker;
        end
    end

endmodule

// File: tb/invadersTb.sv
`timescale 1ns/1ps

module invadersTb
    import invadersPkg::*;
();

    localparam int ClkPeriod = 20;
    localparam int ResetCycles = 16;
    localparam int WatchdogMargin = 500;

    localparam buttons_t PressLeft = 3'b100;
    localparam buttons_t PressRight = 3'b010;
    localparam buttons_t PressFire = 3'b001;

    typedef struct packed {
        buttons_t              press;
        int                    hold;
        int                    jitter;
        int                    settle;
        xCoord_t               minX;
        xCoord_t               maxX;
        alienMask_t            alive;
        logic [ScoreWidth-1:0] score;
        logic                  win;
    } row_t;

    logic clk;
    logic rst;
    buttons_t buttons;
    xCoord_t shipX;
    rocket_t rocket;
    alienMask_t alive;
    logic [ScoreWidth-1:0] score;
    logic win;
    logic speaker;
    logic rowDone;
    logic done;
    xCoord_t expMinX;
    xCoord_t expMaxX;
    alienMask_t expAlive;
    logic [ScoreWidth-1:0] expScore;
    logic expWin;
    int errors;

    row_t rows[$];
    logic [31:0] rngState = 32'he0dc;
    int watchdogCycles = 0;

    always #(ClkPeriod / 2) clk = ~clk;

    invadersTop invadersTop_i (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .shipX   (shipX),
        .rocket  (rocket),
        .alive   (alive),
        .score   (score),
        .win     (win),
        .speaker (speaker)
    );

    invadersChecker invadersChecker_i (
        .clk      (clk),
        .rst      (rst),
        .shipX    (shipX),
        .rocket   (rocket),
        .alive    (alive),
        .score    (score),
        .win      (win),
        .speaker  (speaker),
        .rowDone  (rowDone),
        .expMinX  (expMinX),
        .expMaxX  (expMaxX),
        .expAlive (expAlive),
        .expScore (expScore),
        .expWin   (expWin),
        .done     (done),
        .errors   (errors)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic addRow(input buttons_t press, input int hold, input int jitter,
        input int settle, input int minX, input int maxX, input alienMask_t aliveMask,
        input int points, input logic winFlag);
        row_t r;
        r.press = press;
        r.hold = hold;
        r.jitter = jitter;
        r.settle = settle;
        r.minX = xCoord_t'(minX);
        r.maxX = xCoord_t'(maxX);
        r.alive = aliveMask;
        r.score = ScoreWidth'(points);
        r.win = winFlag;
        rows.push_back(r);
    endtask

    // Moves hold DebounceCycles + n * RepeatCycles for n steps; jitter stays below one step.
    task automatic buildTable();
        addRow(PressLeft, 10, 5, 20, 310, 310, 5'b11111, 0, 1'b0);
        addRow(PressFire, 40, 0, 1700, 310, 310, 5'b11111, 0, 1'b0);
        addRow(PressLeft, DebounceCycles + RepeatCycles * 18, 7, 10, 291, 293, 5'b11111, 0, 1'b0);
        addRow(PressFire, 24, 7, 1300, 291, 293, 5'b11101, 3, 1'b0);
        addRow(PressLeft, DebounceCycles + RepeatCycles * 70, 7, 10, 221, 223, 5'b11101, 3, 1'b0);
        addRow(PressFire, 24, 7, 1300, 221, 223, 5'b11100, 6, 1'b0);
        addRow(PressRight, DebounceCycles + RepeatCycles * 140, 7, 10, 361, 363, 5'b11100, 6, 1'b0);
        addRow(PressFire, 24, 7, 1300, 361, 363, 5'b11000, 9, 1'b0);
        addRow(PressRight, DebounceCycles + RepeatCycles * 70, 7, 10, 431, 433, 5'b11000, 9, 1'b0);
        addRow(PressFire, 24, 7, 1300, 431, 433, 5'b10000, 12, 1'b0);
        addRow(PressRight, DebounceCycles + RepeatCycles * 70, 7, 10, 501, 503, 5'b10000, 12, 1'b0);
        addRow(PressFire, 24, 7, 1300, 501, 503, 5'b00000, 15, 1'b1);
        // Nothing left to hit, and the ship then runs into the right limit.
        addRow(PressFire, 24, 7, 1700, 501, 503, 5'b00000, 15, 1'b1);
        addRow(PressRight, DebounceCycles + RepeatCycles * 110, 7, 10, 598, 598, 5'b00000, 15, 1'b1);
    endtask

    initial
    begin
        row_t r;
        int extra;
        int total;
        clk = 1'b0;
        rst = 1'b1;
        buttons = '0;
        rowDone = 1'b0;
        done = 1'b0;
        expMinX = '0;
        expMaxX = '0;
        expAlive = '0;
        expScore = '0;
        expWin = 1'b0;
        buildTable();
        total = ResetCycles + WatchdogMargin;
        foreach (rows[i])
        begin
            total += rows[i].hold + rows[i].jitter + rows[i].settle + 1;
        end
        watchdogCycles = total;

        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        foreach (rows[i])
        begin
            r = rows[i];
            extra = 0;
            if (r.jitter > 0)
            begin
                rngState = xorshift(rngState);
                extra = int'(rngState % (r.jitter + 1));
            end
            buttons = r.press;
            repeat (r.hold + extra) @(negedge clk);
            buttons = '0;
            repeat (r.settle) @(negedge clk);
            expMinX = r.minX;
            expMaxX = r.maxX;
            expAlive = r.alive;
            expScore = r.score;
            expWin = r.win;
            rowDone = 1'b1;
            @(negedge clk);
            rowDone = 1'b0;
        end
        done = 1'b1;
        @(negedge clk);
        done = 1'b0;
        @(negedge clk);
        if (errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial
    begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the stimulus table did not finish within %0d cycles", watchdogCycles);
        $display("Simulation failed");
        $finish;
    end

endmodule
